/* project.f */
source/mips_exc_pkg.sv
source/exec_lane_register.sv
source/exception_checker.sv
source/exception_arbiter.sv
source/cp0_exception_regs.sv
source/exception_unit.sv
test/tb_clock_gen.sv
test/exception_unit_assertions.sv
test/exception_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds and runs the exception unit testbench with verilator.
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f project.f --top-module exception_unit_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vexception_unit_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation completed successfully" "$log"; then
    exit 0
fi
exit 1

/* test/exception_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exception_unit_tb;

    typedef struct packed {
        mips_exc_pkg::issue_bundle_t issue;
        mips_exc_pkg::tu_bundle_t    tu;
        logic [5:0]                  irq;
        // chase bundle, eret, status write.
        logic [2:0]                  ctl;
        logic                        exp_valid;
        mips_exc_pkg::exc_code_t     exp_code;
        logic                        exp_refill;
        mips_exc_pkg::word_t         exp_epc;
        mips_exc_pkg::word_t         exp_badvaddr;
        logic [1:0]                  exp_commit;
    } entry_t;

    logic                        clk;
    logic                        rst;
    logic                        flush;
    mips_exc_pkg::issue_bundle_t issue;
    mips_exc_pkg::tu_bundle_t    tu_resp;
    logic [5:0]                  ext_int;
    logic                        timer_interrupt;
    mips_exc_pkg::cp0_wr_t       cp0_wr;
    logic                        eret;
    logic                        exception_valid;
    mips_exc_pkg::word_t         pcexception;
    mips_exc_pkg::exception_t    exception_data;
    mips_exc_pkg::issue_bundle_t commit;
    mips_exc_pkg::cp0_status_t   cp0_status;
    mips_exc_pkg::cp0_cause_t    cp0_cause;

    entry_t table_q[$];
    int     errors = 0;
    int     checks = 0;
    logic   exl_model;

    tb_clock_gen clock_i (.clk(clk), .rst(rst));

    exception_unit dut_i (.*);

    // flags are {in_delay_slot, exception_ri, exception_of}.
    function automatic mips_exc_pkg::exec_data_t make_instr(
        input mips_exc_pkg::decoded_op_t op, input mips_exc_pkg::word_t pc,
        input mips_exc_pkg::word_t addr, input logic [2:0] flags);
        mips_exc_pkg::exec_data_t d;
        d = '0;
        d.valid = 1'b1;
        d.instr.op = op;
        d.instr.ctl.memtoreg = op inside {mips_exc_pkg::LW, mips_exc_pkg::LH, mips_exc_pkg::LHU};
        d.instr.ctl.memwrite = op inside {mips_exc_pkg::SW, mips_exc_pkg::SH};
        d.pcplus4 = pc + 32'd4;
        d.result = addr;
        d.in_delay_slot = flags[2];
        d.exception_ri = flags[1];
        d.exception_of = flags[0];
        return d;
    endfunction

    task automatic add_entry(
        input mips_exc_pkg::exec_data_t lane0, input mips_exc_pkg::exec_data_t lane1,
        input logic [5:0] tu, input logic [5:0] irq, input logic [2:0] ctl,
        input logic exp_valid, input mips_exc_pkg::exc_code_t exp_code, input logic exp_refill,
        input mips_exc_pkg::word_t exp_epc, input mips_exc_pkg::word_t exp_badvaddr,
        input logic [1:0] exp_commit);
        entry_t e;
        e.issue[0] = lane0;
        e.issue[1] = lane1;
        e.tu = tu;
        e.irq = irq;
        e.ctl = ctl;
        e.exp_valid = exp_valid;
        e.exp_code = exp_code;
        e.exp_refill = exp_refill;
        e.exp_epc = exp_epc;
        e.exp_badvaddr = exp_badvaddr;
        e.exp_commit = exp_commit;
        table_q.push_back(e);
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // ##########################################################################
    // lane 0, lane 1, tlb per lane in octal {refill, invalid, modified}, ext_int, ctl,
    // then valid, code, refill vector, epc, badvaddr, commit mask.
    // ##########################################################################

    task automatic build_table();
        add_entry(make_instr(mips_exc_pkg::LW, 32'h1000, 32'h2002, 3'o0),
                  make_instr(mips_exc_pkg::ALU, 32'h1004, 32'h0, 3'o0), 6'o00, 6'h00, 3'o0,
                  1'b1, mips_exc_pkg::EXC_ADEL, 1'b0, 32'h1000, 32'h2002, 2'b00);
        add_entry(make_instr(mips_exc_pkg::LH, 32'h1010, 32'h2001, 3'o0), '0, 6'o00, 6'h00, 3'o0,
                  1'b1, mips_exc_pkg::EXC_ADEL, 1'b0, 32'h1010, 32'h2001, 2'b00);
        // store in a delay slot reports the branch.
        add_entry(make_instr(mips_exc_pkg::SW, 32'h1020, 32'h2006, 3'o4), '0, 6'o00, 6'h00, 3'o0,
                  1'b1, mips_exc_pkg::EXC_ADES, 1'b0, 32'h101c, 32'h2006, 2'b00);
        add_entry(make_instr(mips_exc_pkg::ALU, 32'h1030, 32'h0, 3'o0),
                  make_instr(mips_exc_pkg::SYSCALL, 32'h1034, 32'h0, 3'o0), 6'o00, 6'h00, 3'o4,
                  1'b1, mips_exc_pkg::EXC_SYS, 1'b0, 32'h1034, 32'h0, 2'b01);
        add_entry(make_instr(mips_exc_pkg::BREAK, 32'h1040, 32'h0, 3'o0), '0, 6'o00, 6'h00, 3'o0,
                  1'b1, mips_exc_pkg::EXC_BP, 1'b0, 32'h1040, 32'h0, 2'b00);
        add_entry(make_instr(mips_exc_pkg::ALU, 32'h1050, 32'h0, 3'o2), '0, 6'o00, 6'h00, 3'o0,
                  1'b1, mips_exc_pkg::EXC_RI, 1'b0, 32'h1050, 32'h0, 2'b00);
        add_entry(make_instr(mips_exc_pkg::ALU, 32'h1060, 32'h0, 3'o1), '0, 6'o00, 6'h00, 3'o0,
                  1'b1, mips_exc_pkg::EXC_OV, 1'b0, 32'h1060, 32'h0, 2'b00);
        // refill needs exl clear for the refill vector.
        add_entry(make_instr(mips_exc_pkg::LW, 32'h1080, 32'h3000, 3'o0), '0, 6'o04, 6'h00, 3'o2,
                  1'b1, mips_exc_pkg::EXC_TLBL, 1'b1, 32'h1080, 32'h3000, 2'b00);
        add_entry(make_instr(mips_exc_pkg::SW, 32'h1090, 32'h3004, 3'o0), '0, 6'o04, 6'h00, 3'o2,
                  1'b1, mips_exc_pkg::EXC_TLBS, 1'b1, 32'h1090, 32'h3004, 2'b00);
        // invalid stays on the general vector with exl clear.
        add_entry(make_instr(mips_exc_pkg::LW, 32'h10a0, 32'h3008, 3'o0), '0, 6'o02, 6'h00, 3'o2,
                  1'b1, mips_exc_pkg::EXC_TLBL, 1'b0, 32'h10a0, 32'h3008, 2'b00);
        add_entry(make_instr(mips_exc_pkg::SW, 32'h10b0, 32'h300c, 3'o0), '0, 6'o01, 6'h00, 3'o0,
                  1'b1, mips_exc_pkg::EXC_MOD, 1'b0, 32'h10b0, 32'h300c, 2'b00);
        // enable interrupts, leave exception level.
        add_entry('0, '0, 6'o00, 6'h00, 3'o3,
                  1'b0, mips_exc_pkg::EXC_INT, 1'b0, 32'h0, 32'h0, 2'b11);
        add_entry(make_instr(mips_exc_pkg::ALU, 32'h10c0, 32'h0, 3'o0), '0, 6'o00, 6'h01, 3'o0,
                  1'b1, mips_exc_pkg::EXC_INT, 1'b0, 32'h10c0, 32'h0, 2'b00);
        add_entry(make_instr(mips_exc_pkg::ALU, 32'h10d0, 32'h0, 3'o0),
                  make_instr(mips_exc_pkg::ALU, 32'h10d4, 32'h0, 3'o0), 6'o00, 6'h01, 3'o0,
                  1'b0, mips_exc_pkg::EXC_INT, 1'b0, 32'h0, 32'h0, 2'b11);
        add_entry(make_instr(mips_exc_pkg::ALU, 32'h10e0, 32'h0, 3'o0), '0, 6'o00, 6'h20, 3'o2,
                  1'b1, mips_exc_pkg::EXC_INT, 1'b0, 32'h10e0, 32'h0, 2'b00);
        add_entry(make_instr(mips_exc_pkg::LW, 32'h10f0, 32'h4001, 3'o2), '0, 6'o00, 6'h00, 3'o4,
                  1'b1, mips_exc_pkg::EXC_RI, 1'b0, 32'h10f0, 32'h4001, 2'b00);
    endtask

    initial begin
        entry_t                   e;
        mips_exc_pkg::exec_data_t expect_lane;
        flush = 1'b0;
        issue = '0;
        tu_resp = '0;
        ext_int = '0;
        timer_interrupt = 1'b0;
        cp0_wr = '0;
        eret = 1'b0;
        exl_model = 1'b0;
        build_table();
        @(negedge rst);
        @(posedge clk);
        #1;
        foreach (table_q[n]) begin
            e = table_q[n];
            issue = e.issue;
            tu_resp = e.tu;
            ext_int = e.irq;
            cp0_wr = {e.ctl[0], mips_exc_pkg::cp0_sel_status, 32'h0000_ff01};
            eret = e.ctl[1];
            @(posedge clk);
            #1;
            if (e.ctl[1]) begin
                exl_model = 1'b0;
            end
            issue = '0;
            if (e.ctl[2]) begin
                issue[0] = make_instr(mips_exc_pkg::ALU, 32'h5000, 32'h0, 3'o0);
                issue[1] = make_instr(mips_exc_pkg::ALU, 32'h5004, 32'h0, 3'o0);
            end
            cp0_wr = '0;
            eret = 1'b0;
            @(posedge clk);
            #1;
            check_value("exception_valid", 32'(exception_valid), 32'(e.exp_valid));
            if (e.exp_valid) begin
                check_value("exception_data.code", 32'(exception_data.code), 32'(e.exp_code));
                check_value("pcexception", pcexception,
                            e.exp_refill ? mips_exc_pkg::vec_refill : mips_exc_pkg::vec_general);
                check_value("exception_data.epc", exception_data.epc, e.exp_epc);
                if (e.exp_code inside {mips_exc_pkg::EXC_ADEL, mips_exc_pkg::EXC_ADES,
                                       mips_exc_pkg::EXC_TLBL, mips_exc_pkg::EXC_TLBS,
                                       mips_exc_pkg::EXC_MOD}) begin
                    check_value("exception_data.badvaddr", exception_data.badvaddr,
                                e.exp_badvaddr);
                end
                exl_model = 1'b1;
            end
            for (int i = 0; i < mips_exc_pkg::num_lanes; i++) begin
                expect_lane = e.exp_commit[i] ? e.issue[i] : '0;
                checks++;
                if (commit[i] !== expect_lane) begin
                    errors++;
                    $display("Fail commit[%0d]: got %h, expected %h", i, commit[i], expect_lane);
                end
            end
            issue = '0;
            tu_resp = '0;
            ext_int = '0;
            @(posedge clk);
            #1;
            // the bundle behind an exception is dropped.
            check_value("exception_valid", 32'(exception_valid), 32'h0);
            checks++;
            if (commit !== '0) begin
                errors++;
                $display("Fail commit: got %h, expected 0", commit);
            end
            check_value("cp0_status.exl", 32'(cp0_status.exl), 32'(exl_model));
            if (e.exp_valid) begin
                check_value("cp0_cause.exc_code", 32'(cp0_cause.exc_code), 32'(e.exp_code));
            end
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog.
    initial begin
        #1;
        repeat (table_q.size() * 4 + 50) @(posedge clk);
        $display("timeout: the table did not finish within its cycle budget");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* test/exception_unit_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module exception_unit_assertions (
    input logic                                                  clk,
    input logic                                                  rst,
    input mips_exc_pkg::exception_t [mips_exc_pkg::num_lanes-1:0] lane_exc,
    input logic                                                  exception_valid,
    input mips_exc_pkg::exception_t                              exception_data,
    input mips_exc_pkg::issue_bundle_t                           commit
);

    logic code_known;

    always_comb begin
        case (exception_data.code)
            mips_exc_pkg::EXC_INT,
            mips_exc_pkg::EXC_MOD,
            mips_exc_pkg::EXC_TLBL,
            mips_exc_pkg::EXC_TLBS,
            mips_exc_pkg::EXC_ADEL,
            mips_exc_pkg::EXC_ADES,
            mips_exc_pkg::EXC_SYS,
            mips_exc_pkg::EXC_BP,
            mips_exc_pkg::EXC_RI,
            mips_exc_pkg::EXC_OV: code_known = 1'b1;
            default:              code_known = 1'b0;
        endcase
    end

    // reset is synchronous, so the output is low on the edge after rst is seen.
    reset_quiet: assert property (@(posedge clk) rst |=> !exception_valid)
        else $error("exception_valid high after a reset cycle");

    older_lane_wins: assert property (@(posedge clk) disable iff (rst)
        lane_exc[0].valid |=> commit[1] == '0)
        else $error("lane 1 committed behind an excepting lane 0");

    known_code: assert property (@(posedge clk) disable iff (rst)
        exception_valid |-> code_known)
        else $error("exception_valid with an unknown exception code");

endmodule

bind exception_arbiter exception_unit_assertions assertions_i (
    .clk             (clk),
    .rst             (rst),
    .lane_exc        (lane_exc),
    .exception_valid (exception_valid),
    .exception_data  (exception_data),
    .commit          (commit)
);

`default_nettype wire

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // 40 ns period.
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* source/exception_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exception_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,
    input  mips_exc_pkg::issue_bundle_t issue,
    input  mips_exc_pkg::tu_bundle_t    tu_resp,
    input  logic [5:0]                  ext_int,
    input  logic                        timer_interrupt,
    input  mips_exc_pkg::cp0_wr_t       cp0_wr,
    input  logic                        eret,
    output logic                        exception_valid,
    output mips_exc_pkg::word_t         pcexception,
    output mips_exc_pkg::exception_t    exception_data,
    output mips_exc_pkg::issue_bundle_t commit,
    output mips_exc_pkg::cp0_status_t   cp0_status,
    output mips_exc_pkg::cp0_cause_t    cp0_cause
);

    mips_exc_pkg::issue_bundle_t                           stage;
    mips_exc_pkg::exception_t [mips_exc_pkg::num_lanes-1:0] lane_exc;
    logic [mips_exc_pkg::num_lanes-1:0]                    lane_hit;
    logic                                                  kill;

    // the exception registered on this edge drops the bundle issued behind it.
    assign kill = |lane_hit;

    exec_lane_register lane_reg_i (
        .clk   (clk),
        .rst   (rst),
        .flush (flush),
        .kill  (kill),
        .issue (issue),
        .stage (stage)
    );

    generate
        for (genvar i = 0; i < mips_exc_pkg::num_lanes; i++) begin : g_lane
            // interrupts are taken on lane 0 only.
            exception_checker #(
                .take_interrupts (i == 0)
            ) checker_i (
                .data            (stage[i]),
                .tu_op_resp      (tu_resp[i]),
                .ext_int         ((i == 0) ? ext_int : 6'b0),
                .timer_interrupt ((i == 0) ? timer_interrupt : 1'b0),
                .cp0_status      (cp0_status),
                .cp0_cause       (cp0_cause),
                .lane_exc        (lane_exc[i])
            );
            assign lane_hit[i] = lane_exc[i].valid;
        end
    endgenerate

    exception_arbiter arbiter_i (
        .clk             (clk),
        .rst             (rst),
        .lane_exc        (lane_exc),
        .stage           (stage),
        .cp0_status      (cp0_status),
        .exception_valid (exception_valid),
        .pcexception     (pcexception),
        .exception_data  (exception_data),
        .commit          (commit)
    );

    cp0_exception_regs cp0_i (
        .clk             (clk),
        .rst             (rst),
        .exception_valid (exception_valid),
        .exception_data  (exception_data),
        .eret            (eret),
        .cp0_wr          (cp0_wr),
        .ext_int         (ext_int),
        .timer_interrupt (timer_interrupt),
        .cp0_status      (cp0_status),
        .cp0_cause       (cp0_cause)
    );

endmodule

`default_nettype wire

/* source/cp0_exception_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module cp0_exception_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      exception_valid,
    input  mips_exc_pkg::exception_t  exception_data,
    input  logic                      eret,
    input  mips_exc_pkg::cp0_wr_t     cp0_wr,
    input  logic [5:0]                ext_int,
    input  logic                      timer_interrupt,
    output mips_exc_pkg::cp0_status_t cp0_status,
    output mips_exc_pkg::cp0_cause_t  cp0_cause
);

    always_ff @(posedge clk) begin
        if (rst) begin
            cp0_status <= '0;
            cp0_cause  <= '0;
        end else begin
            // hardware ip bits track the interrupt lines.
            cp0_cause.ip[7:2] <= {ext_int[5] | timer_interrupt, ext_int[4:0]};
            if (exception_valid) begin
                cp0_status.exl     <= 1'b1;
                cp0_cause.bd       <= exception_data.in_delay_slot;
                cp0_cause.exc_code <= exception_data.code;
            end else if (eret) begin
                cp0_status.exl <= 1'b0;
            end
            if (cp0_wr.en && cp0_wr.sel == mips_exc_pkg::cp0_sel_status) begin
                cp0_status.im <= cp0_wr.data[15:8];
                cp0_status.ie <= cp0_wr.data[0];
            end
            if (cp0_wr.en && cp0_wr.sel == mips_exc_pkg::cp0_sel_cause) begin
                cp0_cause.ip[1:0] <= cp0_wr.data[9:8];
            end
        end
    end

endmodule

`default_nettype wire

/* source/exception_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module exception_arbiter (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  mips_exc_pkg::exception_t [mips_exc_pkg::num_lanes-1:0] lane_exc,
    input  mips_exc_pkg::issue_bundle_t                           stage,
    input  mips_exc_pkg::cp0_status_t                             cp0_status,
    output logic                                                  exception_valid,
    output mips_exc_pkg::word_t                                   pcexception,
    output mips_exc_pkg::exception_t                              exception_data,
    output mips_exc_pkg::issue_bundle_t                           commit
);

    logic                        hit;
    mips_exc_pkg::exception_t    sel_exc;
    mips_exc_pkg::issue_bundle_t commit_d;
    mips_exc_pkg::word_t         vector;

    // lane 0 is the oldest. the first excepting lane and all younger ones are dropped.
    always_comb begin
        hit      = 1'b0;
        sel_exc  = '0;
        commit_d = stage;
        for (int i = 0; i < mips_exc_pkg::num_lanes; i++) begin
            if (!hit && lane_exc[i].valid) begin
                hit     = 1'b1;
                sel_exc = lane_exc[i];
            end
            if (hit) begin
                commit_d[i] = '0;
            end
        end
    end

    // a refill taken while already at exception level goes to the general vector.
    assign vector = (sel_exc.tlb_refill && !cp0_status.exl) ? mips_exc_pkg::vec_refill :
                                                              mips_exc_pkg::vec_general;

    always_ff @(posedge clk) begin
        if (rst) begin
            exception_valid <= 1'b0;
            commit          <= '0;
        end else begin
            exception_valid <= hit;
            commit          <= commit_d;
        end
    end

    always_ff @(posedge clk) begin
        pcexception    <= vector;
        exception_data <= sel_exc;
    end

endmodule

`default_nettype wire

/* source/exception_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module exception_checker #(
    parameter bit take_interrupts = 1'b0
) (
    input  mips_exc_pkg::exec_data_t  data,
    input  mips_exc_pkg::tu_op_resp_t tu_op_resp,
    input  logic [5:0]                ext_int,
    input  logic                      timer_interrupt,
    input  mips_exc_pkg::cp0_status_t cp0_status,
    input  mips_exc_pkg::cp0_cause_t  cp0_cause,
    output mips_exc_pkg::exception_t  lane_exc
);

    mips_exc_pkg::decoded_op_t op;
    mips_exc_pkg::word_t       pc;
    mips_exc_pkg::word_t       addr;
    logic [7:0]                pending;
    logic                      int_req;
    logic                      data_read;
    logic                      data_write;
    logic                      load_mis;
    logic                      store_mis;
    logic                      instr_tlb;
    logic                      data_tlb;
    logic                      data_mod;

    assign op   = data.instr.op;
    assign pc   = data.pcplus4 - 32'd4;
    assign addr = data.result;

    assign data_read  = data.instr.ctl.memtoreg;
    assign data_write = data.instr.ctl.memwrite;

    assign load_mis  = ((op == mips_exc_pkg::LW) && (addr[1:0] != 2'b00)) ||
                       ((op == mips_exc_pkg::LH || op == mips_exc_pkg::LHU) && addr[0]);
    assign store_mis = ((op == mips_exc_pkg::SW) && (addr[1:0] != 2'b00)) ||
                       ((op == mips_exc_pkg::SH) && addr[0]);

    assign instr_tlb = data.instr_tlb_refill | data.instr_tlb_invalid;
    assign data_tlb  = (tu_op_resp.d_tlb_refill | tu_op_resp.d_tlb_invalid) &
                       (data_read | data_write);
    assign data_mod  = tu_op_resp.d_tlb_modified & data_write;

    // timer shares ip7 with the top hardware line.
    assign pending = ({ext_int, 2'b00} | cp0_cause.ip | {timer_interrupt, 7'b0}) &
                     cp0_status.im;
    assign int_req = take_interrupts && cp0_status.ie && !cp0_status.exl &&
                     (pending != 8'h00);

    // ########################################################################
    // priority encoding, highest first.
    // ########################################################################

    always_comb begin
        lane_exc               = '0;
        lane_exc.valid         = data.valid;
        lane_exc.epc           = data.in_delay_slot ? (pc - 32'd4) : pc;
        lane_exc.badvaddr      = addr;
        lane_exc.in_delay_slot = data.in_delay_slot;
        if (int_req) begin
            lane_exc.code = mips_exc_pkg::EXC_INT;
        end else if (data.exception_instr) begin
            lane_exc.code     = mips_exc_pkg::EXC_ADEL;
            lane_exc.badvaddr = pc;
        end else if (instr_tlb) begin
            lane_exc.code       = mips_exc_pkg::EXC_TLBL;
            lane_exc.badvaddr   = pc;
            lane_exc.tlb_refill = data.instr_tlb_refill;
        end else if (data.exception_ri) begin
            lane_exc.code = mips_exc_pkg::EXC_RI;
        end else if (op == mips_exc_pkg::SYSCALL) begin
            lane_exc.code = mips_exc_pkg::EXC_SYS;
        end else if (op == mips_exc_pkg::BREAK) begin
            lane_exc.code = mips_exc_pkg::EXC_BP;
        end else if (data.exception_of) begin
            lane_exc.code = mips_exc_pkg::EXC_OV;
        end else if (load_mis) begin
            lane_exc.code = mips_exc_pkg::EXC_ADEL;
        end else if (store_mis) begin
            lane_exc.code = mips_exc_pkg::EXC_ADES;
        end else if (data_tlb) begin
            lane_exc.code       = data_write ? mips_exc_pkg::EXC_TLBS : mips_exc_pkg::EXC_TLBL;
            lane_exc.tlb_refill = tu_op_resp.d_tlb_refill;
        end else if (data_mod) begin
            lane_exc.code = mips_exc_pkg::EXC_MOD;
        end else begin
            // no cause in this lane.
            lane_exc.valid = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* source/exec_lane_register.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_lane_register (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,
    input  logic                        kill,
    input  mips_exc_pkg::issue_bundle_t issue,
    output mips_exc_pkg::issue_bundle_t stage
);

    logic clear;

    // an exception in the stage drops the bundle arriving behind it.
    assign clear = rst | flush | kill;

    always_ff @(posedge clk) begin
        if (clear) begin
            stage <= '0;
        end else begin
            stage <= issue;
        end
    end

endmodule

`default_nettype wire

/* source/mips_exc_pkg.sv */
`default_nettype none

package mips_exc_pkg;

    // #########################################################################
    // words, issue width and handler vectors.
    // #########################################################################

    typedef logic [31:0] word_t;

    localparam int num_lanes = 2;

    localparam word_t vec_refill  = 32'h8000_0000;
    localparam word_t vec_general = 32'h8000_0180;

    // software write targets.
    localparam logic cp0_sel_status = 1'b0;
    localparam logic cp0_sel_cause  = 1'b1;

    // #########################################################################
    // memory-stage instruction records.
    // #########################################################################

    typedef enum logic [3:0] {
        NOP     = 4'd0,
        LW      = 4'd1,
        LH      = 4'd2,
        LHU     = 4'd3,
        SW      = 4'd4,
        SH      = 4'd5,
        SYSCALL = 4'd6,
        BREAK   = 4'd7,
        ALU     = 4'd8
    } decoded_op_t;

    typedef struct packed {
        logic memwrite;
        logic memtoreg;
    } ctl_t;

    typedef struct packed {
        decoded_op_t op;
        ctl_t        ctl;
    } instr_t;

    typedef struct packed {
        logic   valid;
        instr_t instr;
        word_t  pcplus4;
        // alu result, or the data address for loads and stores.
        word_t  result;
        logic   in_delay_slot;
        logic   exception_instr;
        logic   exception_ri;
        logic   exception_of;
        logic   instr_tlb_invalid;
        logic   instr_tlb_refill;
    } exec_data_t;

    typedef exec_data_t [num_lanes-1:0] issue_bundle_t;

    typedef struct packed {
        logic d_tlb_refill;
        logic d_tlb_invalid;
        logic d_tlb_modified;
    } tu_op_resp_t;

    typedef tu_op_resp_t [num_lanes-1:0] tu_bundle_t;

    // #########################################################################
    // exceptions and cp0.
    // #########################################################################

    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_MOD  = 5'd1,
        EXC_TLBL = 5'd2,
        EXC_TLBS = 5'd3,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12
    } exc_code_t;

    typedef struct packed {
        logic      valid;
        exc_code_t code;
        word_t     epc;
        word_t     badvaddr;
        logic      in_delay_slot;
        logic      tlb_refill;
    } exception_t;

    typedef struct packed {
        logic [7:0] im;
        logic       exl;
        logic       ie;
    } cp0_status_t;

    typedef struct packed {
        logic       bd;
        logic [7:0] ip;
        exc_code_t  exc_code;
    } cp0_cause_t;

    // status takes im from data[15:8] and ie from data[0], cause takes ip[1:0] from data[9:8].
    typedef struct packed {
        logic  en;
        logic  sel;
        word_t data;
    } cp0_wr_t;

endpackage

`default_nettype wire
